//--- src/cpu_pkg.sv
package cpu_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    // Source of the register write data
    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_PC4
    } wb_sel_e;

    // Operand source in execute
    typedef enum logic [1:0] {
        FWD_RF,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

endpackage

//--- src/fetch.sv
module fetch (
    input  logic           clk,
    input  logic           arst_n_i,
    input  logic           stall_i,
    input  logic           flush_i,
    input  logic           redirect_i,
    input  cpu_pkg::word_t redirect_pc_i,
    input  cpu_pkg::word_t imem_instr_i,
    output cpu_pkg::word_t pc_o,
    output cpu_pkg::word_t pc_id_o,
    output cpu_pkg::word_t instr_id_o,
    output logic           valid_id_o
);

    // A redirect wins over a stall
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_o <= '0;
        end else if (redirect_i) begin
            pc_o <= redirect_pc_i;
        end else if (!stall_i) begin
            pc_o <= pc_o + 32'd4;
        end
    end

    // IF/ID valid bit
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_id_o <= 1'b0;
        end else if (flush_i) begin
            valid_id_o <= 1'b0;
        end else if (!stall_i) begin
            valid_id_o <= 1'b1;
        end
    end

    // IF/ID payload is held during a stall
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            pc_id_o    <= pc_o;
            instr_id_o <= imem_instr_i;
        end
    end

endmodule

//--- src/decode.sv
module decode (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              stall_i,
    input  logic              flush_i,
    input  cpu_pkg::word_t    pc_i,
    input  cpu_pkg::word_t    instr_i,
    input  logic              valid_i,
    input  cpu_pkg::word_t    rs1_data_i,
    input  cpu_pkg::word_t    rs2_data_i,
    output logic [4:0]        rs1_addr_o,
    output logic [4:0]        rs2_addr_o,
    output logic [4:0]        rs1_addr_ex_o,
    output logic [4:0]        rs2_addr_ex_o,
    output logic [4:0]        rd_addr_ex_o,
    output cpu_pkg::word_t    pc_ex_o,
    output cpu_pkg::word_t    rs1_data_ex_o,
    output cpu_pkg::word_t    rs2_data_ex_o,
    output cpu_pkg::word_t    imm_ex_o,
    output cpu_pkg::alu_op_e  alu_op_ex_o,
    output logic              use_imm_ex_o,
    output cpu_pkg::wb_sel_e  wb_sel_ex_o,
    output logic              rf_w_en_ex_o,
    output logic              mem_w_en_ex_o,
    output logic              is_load_ex_o,
    output logic              is_branch_ex_o,
    output logic              is_jal_ex_o
);
    import cpu_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm;
    alu_op_e    alu_op;
    wb_sel_e    wb_sel;
    logic       legal;
    logic       use_imm;
    logic       rf_w_en;
    logic       mem_w_en;
    logic       is_load;
    logic       is_branch;
    logic       is_jal;
    logic       take;

    assign opcode     = opcode_e'(instr_i[6:0]);
    assign funct3     = instr_i[14:12];
    assign funct7     = instr_i[31:25];
    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];

    always_comb begin
        legal     = 1'b0;
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        wb_sel    = WB_ALU;
        rf_w_en   = 1'b0;
        mem_w_en  = 1'b0;
        is_load   = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        // I-type by default
        imm       = {{20{instr_i[31]}}, instr_i[31:20]};
        case (opcode)
            OPC_OP: begin
                legal   = 1'b1;
                rf_w_en = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: alu_op = ALU_SUB;
                    {7'b0000000, 3'b111}: alu_op = ALU_AND;
                    {7'b0000000, 3'b110}: alu_op = ALU_OR;
                    {7'b0000000, 3'b100}: alu_op = ALU_XOR;
                    {7'b0000000, 3'b010}: alu_op = ALU_SLT;
                    default: legal = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                legal   = (funct3 == 3'b000);
                rf_w_en = 1'b1;
                use_imm = 1'b1;
            end
            OPC_LUI: begin
                legal   = 1'b1;
                rf_w_en = 1'b1;
                use_imm = 1'b1;
                alu_op  = ALU_PASS_B;
                imm     = {instr_i[31:12], 12'b0};
            end
            OPC_LOAD: begin
                legal   = (funct3 == 3'b010);
                rf_w_en = 1'b1;
                use_imm = 1'b1;
                wb_sel  = WB_LOAD;
                is_load = 1'b1;
            end
            OPC_STORE: begin
                legal    = (funct3 == 3'b010);
                use_imm  = 1'b1;
                mem_w_en = 1'b1;
                imm      = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            end
            OPC_BRANCH: begin
                // BEQ only
                legal     = (funct3 == 3'b000);
                is_branch = 1'b1;
                imm       = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                             instr_i[30:25], instr_i[11:8], 1'b0};
            end
            OPC_JAL: begin
                legal   = 1'b1;
                rf_w_en = 1'b1;
                wb_sel  = WB_PC4;
                is_jal  = 1'b1;
                imm     = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                           instr_i[20], instr_i[30:21], 1'b0};
            end
            default: legal = 1'b0;
        endcase
    end

    // Stall, flush or an unsupported instruction all become a bubble
    assign take = valid_i && legal && !stall_i && !flush_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rs1_addr_ex_o  <= '0;
            rs2_addr_ex_o  <= '0;
            rd_addr_ex_o   <= '0;
            alu_op_ex_o    <= ALU_ADD;
            use_imm_ex_o   <= 1'b0;
            wb_sel_ex_o    <= WB_ALU;
            rf_w_en_ex_o   <= 1'b0;
            mem_w_en_ex_o  <= 1'b0;
            is_load_ex_o   <= 1'b0;
            is_branch_ex_o <= 1'b0;
            is_jal_ex_o    <= 1'b0;
        end else begin
            rs1_addr_ex_o  <= rs1_addr_o;
            rs2_addr_ex_o  <= rs2_addr_o;
            rd_addr_ex_o   <= instr_i[11:7];
            alu_op_ex_o    <= alu_op;
            use_imm_ex_o   <= use_imm;
            wb_sel_ex_o    <= wb_sel;
            rf_w_en_ex_o   <= take && rf_w_en;
            mem_w_en_ex_o  <= take && mem_w_en;
            is_load_ex_o   <= take && is_load;
            is_branch_ex_o <= take && is_branch;
            is_jal_ex_o    <= take && is_jal;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        pc_ex_o       <= pc_i;
        rs1_data_ex_o <= rs1_data_i;
        rs2_data_ex_o <= rs2_data_i;
        imm_ex_o      <= imm;
    end

endmodule

//--- src/regfile.sv
module regfile (
    input  logic           clk,
    input  logic           arst_n_i,
    input  logic           w_en_i,
    input  logic [4:0]     w_addr_i,
    input  cpu_pkg::word_t w_data_i,
    input  logic [4:0]     ra_addr_i,
    input  logic [4:0]     rb_addr_i,
    output cpu_pkg::word_t ra_data_o,
    output cpu_pkg::word_t rb_data_o
);
    import cpu_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (w_en_i && w_addr_i != 5'd0) begin
            regs[w_addr_i] <= w_data_i;
        end
    end

    // x0 reads zero and a same-cycle write is bypassed
    assign ra_data_o = (ra_addr_i == 5'd0) ? '0 :
                       (w_en_i && w_addr_i == ra_addr_i) ? w_data_i : regs[ra_addr_i];
    assign rb_data_o = (rb_addr_i == 5'd0) ? '0 :
                       (w_en_i && w_addr_i == rb_addr_i) ? w_data_i : regs[rb_addr_i];

endmodule

//--- src/execute.sv
module execute (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic [4:0]        rd_addr_i,
    input  cpu_pkg::word_t    pc_i,
    input  cpu_pkg::word_t    rs1_data_i,
    input  cpu_pkg::word_t    rs2_data_i,
    input  cpu_pkg::word_t    imm_i,
    input  cpu_pkg::alu_op_e  alu_op_i,
    input  logic              use_imm_i,
    input  cpu_pkg::wb_sel_e  wb_sel_i,
    input  logic              rf_w_en_i,
    input  logic              mem_w_en_i,
    input  logic              is_branch_i,
    input  logic              is_jal_i,
    input  cpu_pkg::fwd_sel_e fwd_a_i,
    input  cpu_pkg::fwd_sel_e fwd_b_i,
    input  cpu_pkg::word_t    mem_fwd_i,
    input  cpu_pkg::word_t    wb_fwd_i,
    output logic              redirect_o,
    output cpu_pkg::word_t    redirect_pc_o,
    output cpu_pkg::word_t    alu_out_mem_o,
    output cpu_pkg::word_t    rs2_data_mem_o,
    output logic [4:0]        rd_addr_mem_o,
    output logic              rf_w_en_mem_o,
    output logic              mem_w_en_mem_o,
    output cpu_pkg::wb_sel_e  wb_sel_mem_o,
    output cpu_pkg::word_t    pc4_mem_o
);
    import cpu_pkg::*;

    word_t op_a;
    word_t rs2_val;
    word_t op_b;
    word_t alu_out;

    // Forwarding muxes
    always_comb begin
        case (fwd_a_i)
            FWD_MEM: op_a = mem_fwd_i;
            FWD_WB:  op_a = wb_fwd_i;
            default: op_a = rs1_data_i;
        endcase
        case (fwd_b_i)
            FWD_MEM: rs2_val = mem_fwd_i;
            FWD_WB:  rs2_val = wb_fwd_i;
            default: rs2_val = rs2_data_i;
        endcase
    end

    assign op_b = use_imm_i ? imm_i : rs2_val;

    always_comb begin
        case (alu_op_i)
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SLT:    alu_out = word_t'($signed(op_a) < $signed(op_b));
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    // A taken BEQ or a JAL jumps relative to its own pc
    assign redirect_o    = is_jal_i || (is_branch_i && op_a == rs2_val);
    assign redirect_pc_o = pc_i + imm_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_addr_mem_o  <= '0;
            rf_w_en_mem_o  <= 1'b0;
            mem_w_en_mem_o <= 1'b0;
            wb_sel_mem_o   <= WB_ALU;
        end else begin
            rd_addr_mem_o  <= rd_addr_i;
            rf_w_en_mem_o  <= rf_w_en_i;
            mem_w_en_mem_o <= mem_w_en_i;
            wb_sel_mem_o   <= wb_sel_i;
        end
    end

    // EX/MEM payload
    always_ff @(posedge clk) begin
        alu_out_mem_o  <= alu_out;
        rs2_data_mem_o <= rs2_val;
        pc4_mem_o      <= pc_i + 32'd4;
    end

endmodule

//--- src/memory_access.sv
module memory_access #(
    parameter int DMEM_AW = 6
) (
    input  logic               clk,
    input  logic               arst_n_i,
    input  cpu_pkg::word_t     alu_out_i,
    input  cpu_pkg::word_t     rs2_data_i,
    input  logic [4:0]         rd_addr_i,
    input  logic               rf_w_en_i,
    input  logic               mem_w_en_i,
    input  cpu_pkg::wb_sel_e   wb_sel_i,
    input  cpu_pkg::word_t     pc4_i,
    input  cpu_pkg::word_t     dmem_rdata_i,
    output logic               dmem_w_en_o,
    output logic [DMEM_AW-1:0] dmem_addr_o,
    output cpu_pkg::word_t     dmem_wdata_o,
    output cpu_pkg::word_t     mem_fwd_o,
    output logic               rf_w_en_o,
    output logic [4:0]         rf_w_addr_o,
    output cpu_pkg::word_t     rf_w_data_o
);
    import cpu_pkg::*;

    wb_sel_e wb_sel_wb;
    word_t   result_wb;
    word_t   load_wb;

    // Word addressed store port
    assign dmem_w_en_o  = mem_w_en_i;
    assign dmem_addr_o  = alu_out_i[DMEM_AW+1:2];
    assign dmem_wdata_o = rs2_data_i;

    // Load data is not ready yet here
    assign mem_fwd_o = (wb_sel_i == WB_PC4) ? pc4_i : alu_out_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rf_w_en_o   <= 1'b0;
            rf_w_addr_o <= '0;
            wb_sel_wb   <= WB_ALU;
        end else begin
            rf_w_en_o   <= rf_w_en_i;
            rf_w_addr_o <= rd_addr_i;
            wb_sel_wb   <= wb_sel_i;
        end
    end

    always_ff @(posedge clk) begin
        result_wb <= mem_fwd_o;
        load_wb   <= dmem_rdata_i;
    end

    assign rf_w_data_o = (wb_sel_wb == WB_LOAD) ? load_wb : result_wb;

endmodule

//--- src/hazard_detect.sv
module hazard_detect (
    input  logic              [4:0] rs1_addr_id_i,
    input  logic              [4:0] rs2_addr_id_i,
    input  logic              [4:0] rs1_addr_ex_i,
    input  logic              [4:0] rs2_addr_ex_i,
    input  logic              [4:0] rd_addr_ex_i,
    input  logic                    is_load_ex_i,
    input  logic                    redirect_i,
    input  logic              [4:0] rd_addr_mem_i,
    input  logic                    rf_w_en_mem_i,
    input  logic              [4:0] rd_addr_wb_i,
    input  logic                    rf_w_en_wb_i,
    output cpu_pkg::fwd_sel_e       fwd_a_o,
    output cpu_pkg::fwd_sel_e       fwd_b_o,
    output logic                    stall_o,
    output logic                    flush_o
);
    import cpu_pkg::*;

    // Youngest producer wins
    function automatic fwd_sel_e fwd_pick(input logic [4:0] rs);
        fwd_sel_e sel;
        sel = FWD_RF;
        if (rf_w_en_wb_i && rd_addr_wb_i != 5'd0 && rd_addr_wb_i == rs) begin
            sel = FWD_WB;
        end
        if (rf_w_en_mem_i && rd_addr_mem_i != 5'd0 && rd_addr_mem_i == rs) begin
            sel = FWD_MEM;
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a_o = fwd_pick(rs1_addr_ex_i);
        fwd_b_o = fwd_pick(rs2_addr_ex_i);
    end

    // Load result is only available from writeback
    assign stall_o = is_load_ex_i && rd_addr_ex_i != 5'd0 &&
                     (rd_addr_ex_i == rs1_addr_id_i || rd_addr_ex_i == rs2_addr_id_i);

    assign flush_o = redirect_i;

endmodule

//--- src/cpu.sv
module cpu #(
    parameter int DMEM_AW = 6
) (
    input  logic               clk,
    input  logic               arst_n_i,
    input  cpu_pkg::word_t     imem_instr_i,
    output cpu_pkg::word_t     pc_o,
    input  cpu_pkg::word_t     dmem_rdata_i,
    output logic               dmem_w_en_o,
    output logic [DMEM_AW-1:0] dmem_addr_o,
    output cpu_pkg::word_t     dmem_wdata_o
);
    import cpu_pkg::*;

    // Hazard control
    logic       stall;
    logic       flush;
    fwd_sel_e   fwd_a;
    fwd_sel_e   fwd_b;

    // Redirect from execute
    logic       redirect;
    word_t      redirect_pc;

    // IF/ID and register reads
    word_t      pc_id;
    word_t      instr_id;
    logic       valid_id;
    logic [4:0] rs1_addr_id;
    logic [4:0] rs2_addr_id;
    word_t      rs1_data_id;
    word_t      rs2_data_id;

    // ID/EX
    logic [4:0] rs1_addr_ex;
    logic [4:0] rs2_addr_ex;
    logic [4:0] rd_addr_ex;
    word_t      pc_ex;
    word_t      rs1_data_ex;
    word_t      rs2_data_ex;
    word_t      imm_ex;
    alu_op_e    alu_op_ex;
    wb_sel_e    wb_sel_ex;
    logic       use_imm_ex;
    logic       rf_w_en_ex;
    logic       mem_w_en_ex;
    logic       is_load_ex;
    logic       is_branch_ex;
    logic       is_jal_ex;

    // EX/MEM
    word_t      alu_out_mem;
    word_t      rs2_data_mem;
    word_t      pc4_mem;
    word_t      mem_fwd;
    logic [4:0] rd_addr_mem;
    logic       rf_w_en_mem;
    logic       mem_w_en_mem;
    wb_sel_e    wb_sel_mem;

    // Register write port from writeback
    logic       rf_w_en_wb;
    logic [4:0] rd_addr_wb;
    word_t      rf_w_data_wb;

    fetch fetch0 (
        .clk(clk), .arst_n_i(arst_n_i),
        .stall_i(stall), .flush_i(flush),
        .redirect_i(redirect), .redirect_pc_i(redirect_pc),
        .imem_instr_i(imem_instr_i), .pc_o(pc_o),
        .pc_id_o(pc_id), .instr_id_o(instr_id), .valid_id_o(valid_id)
    );

    decode decode0 (
        .clk(clk), .arst_n_i(arst_n_i),
        .stall_i(stall), .flush_i(flush),
        .pc_i(pc_id), .instr_i(instr_id), .valid_i(valid_id),
        .rs1_data_i(rs1_data_id), .rs2_data_i(rs2_data_id),
        .rs1_addr_o(rs1_addr_id), .rs2_addr_o(rs2_addr_id),
        .rs1_addr_ex_o(rs1_addr_ex), .rs2_addr_ex_o(rs2_addr_ex),
        .rd_addr_ex_o(rd_addr_ex), .pc_ex_o(pc_ex),
        .rs1_data_ex_o(rs1_data_ex), .rs2_data_ex_o(rs2_data_ex),
        .imm_ex_o(imm_ex), .alu_op_ex_o(alu_op_ex),
        .use_imm_ex_o(use_imm_ex), .wb_sel_ex_o(wb_sel_ex),
        .rf_w_en_ex_o(rf_w_en_ex), .mem_w_en_ex_o(mem_w_en_ex),
        .is_load_ex_o(is_load_ex), .is_branch_ex_o(is_branch_ex),
        .is_jal_ex_o(is_jal_ex)
    );

    regfile regfile0 (
        .clk(clk), .arst_n_i(arst_n_i),
        .w_en_i(rf_w_en_wb), .w_addr_i(rd_addr_wb), .w_data_i(rf_w_data_wb),
        .ra_addr_i(rs1_addr_id), .rb_addr_i(rs2_addr_id),
        .ra_data_o(rs1_data_id), .rb_data_o(rs2_data_id)
    );

    execute exec0 (
        .clk(clk), .arst_n_i(arst_n_i),
        .rd_addr_i(rd_addr_ex), .pc_i(pc_ex),
        .rs1_data_i(rs1_data_ex), .rs2_data_i(rs2_data_ex),
        .imm_i(imm_ex), .alu_op_i(alu_op_ex), .use_imm_i(use_imm_ex),
        .wb_sel_i(wb_sel_ex), .rf_w_en_i(rf_w_en_ex), .mem_w_en_i(mem_w_en_ex),
        .is_branch_i(is_branch_ex), .is_jal_i(is_jal_ex),
        .fwd_a_i(fwd_a), .fwd_b_i(fwd_b),
        .mem_fwd_i(mem_fwd), .wb_fwd_i(rf_w_data_wb),
        .redirect_o(redirect), .redirect_pc_o(redirect_pc),
        .alu_out_mem_o(alu_out_mem), .rs2_data_mem_o(rs2_data_mem),
        .rd_addr_mem_o(rd_addr_mem), .rf_w_en_mem_o(rf_w_en_mem),
        .mem_w_en_mem_o(mem_w_en_mem), .wb_sel_mem_o(wb_sel_mem),
        .pc4_mem_o(pc4_mem)
    );

    memory_access #(
        .DMEM_AW(DMEM_AW)
    ) memaccess0 (
        .clk(clk), .arst_n_i(arst_n_i),
        .alu_out_i(alu_out_mem), .rs2_data_i(rs2_data_mem),
        .rd_addr_i(rd_addr_mem), .rf_w_en_i(rf_w_en_mem),
        .mem_w_en_i(mem_w_en_mem), .wb_sel_i(wb_sel_mem), .pc4_i(pc4_mem),
        .dmem_rdata_i(dmem_rdata_i), .dmem_w_en_o(dmem_w_en_o),
        .dmem_addr_o(dmem_addr_o), .dmem_wdata_o(dmem_wdata_o),
        .mem_fwd_o(mem_fwd), .rf_w_en_o(rf_w_en_wb),
        .rf_w_addr_o(rd_addr_wb), .rf_w_data_o(rf_w_data_wb)
    );

    hazard_detect hazard_detect0 (
        .rs1_addr_id_i(rs1_addr_id), .rs2_addr_id_i(rs2_addr_id),
        .rs1_addr_ex_i(rs1_addr_ex), .rs2_addr_ex_i(rs2_addr_ex),
        .rd_addr_ex_i(rd_addr_ex), .is_load_ex_i(is_load_ex),
        .redirect_i(redirect),
        .rd_addr_mem_i(rd_addr_mem), .rf_w_en_mem_i(rf_w_en_mem),
        .rd_addr_wb_i(rd_addr_wb), .rf_w_en_wb_i(rf_w_en_wb),
        .fwd_a_o(fwd_a), .fwd_b_o(fwd_b),
        .stall_o(stall), .flush_o(flush)
    );

endmodule

//--- verification/cpu_clkgen.sv
module cpu_clkgen (
    input  logic restart_i,
    output logic clk_o,
    output logic arst_n_o
);

    int rst_cnt = 2;

    initial begin
        clk_o    = 1'b0;
        arst_n_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // Reset stays low for two rising edges and again after each restart
    always @(posedge clk_o) begin
        if (restart_i) begin
            arst_n_o <= 1'b0;
            rst_cnt  <= 2;
        end else if (rst_cnt > 1) begin
            rst_cnt <= rst_cnt - 1;
        end else if (rst_cnt == 1) begin
            rst_cnt  <= 0;
            arst_n_o <= 1'b1;
        end
    end

endmodule

//--- verification/cpu_assert.sv
module cpu_assert (
    input logic           clk,
    input logic           arst_n_i,
    input cpu_pkg::word_t pc_i,
    input logic           dmem_w_en_i,
    input logic           stall_i,
    input logic           flush_i
);

    pc_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
        pc_i[1:0] == 2'b00)
        else $error("pc is not word aligned");

    no_store_in_reset: assert property (@(posedge clk)
        !arst_n_i |-> !dmem_w_en_i)
        else $error("store strobe high during reset");

    // A stall without a redirect freezes the pc
    stall_holds_pc: assert property (@(posedge clk) disable iff (!arst_n_i)
        stall_i && !flush_i |=> $stable(pc_i))
        else $error("pc moved during a stall");

endmodule

bind cpu cpu_assert assert_i (
    .clk(clk),
    .arst_n_i(arst_n_i),
    .pc_i(pc_o),
    .dmem_w_en_i(dmem_w_en_o),
    .stall_i(stall),
    .flush_i(flush)
);

//--- verification/cpu_tb.sv
module cpu_tb;
    import cpu_pkg::*;

    localparam int DMEM_AW     = 6;
    localparam int NUM_PROGS   = 20;
    localparam int BODY_LEN    = 40;
    localparam int PROG_LEN    = 48;
    localparam int CYCLE_LIMIT = NUM_PROGS * (PROG_LEN * 4 + 20);

    typedef logic [DMEM_AW-1:0] daddr_t;
    typedef enum {
        K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT,
        K_ADDI, K_LUI, K_LW, K_SW, K_BEQ, K_JAL
    } kind_e;

    logic   clk;
    logic   arst_n;
    logic   restart;
    word_t  imem_instr;
    word_t  pc;
    word_t  dmem_rdata;
    logic   dmem_w_en;
    daddr_t dmem_addr;
    word_t  dmem_wdata;

    // Program as fields, plus its encoding
    kind_e      kind [PROG_LEN];
    logic [4:0] rd   [PROG_LEN];
    logic [4:0] rs1  [PROG_LEN];
    logic [4:0] rs2  [PROG_LEN];
    int         imm  [PROG_LEN];
    word_t      imem [64];
    word_t      dmem [64];

    daddr_t exp_addr [$];
    word_t  exp_data [$];
    int     seen;
    int     prog;
    int     cycles;
    int     fail_count;
    logic   pend_en;
    daddr_t pend_addr;
    word_t  pend_data;

    cpu_clkgen clkgen_i (
        .restart_i(restart),
        .clk_o(clk),
        .arst_n_o(arst_n)
    );

    cpu #(
        .DMEM_AW(DMEM_AW)
    ) dut_i (
        .clk(clk),
        .arst_n_i(arst_n),
        .imem_instr_i(imem_instr),
        .pc_o(pc),
        .dmem_rdata_i(dmem_rdata),
        .dmem_w_en_o(dmem_w_en),
        .dmem_addr_o(dmem_addr),
        .dmem_wdata_o(dmem_wdata)
    );

    // Both memories read combinationally
    assign imem_instr = (pc[31:8] == 24'd0) ? imem[pc[7:2]] : '0;
    assign dmem_rdata = dmem[dmem_addr];

    task automatic abort_run(input string why);
        fail_count++;
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input daddr_t exp, input daddr_t act);
        if (exp !== act) begin
            abort_run($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_data(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            abort_run($sformatf("MISMATCH %s expected %08h actual %08h", name, exp, act));
        end
    endtask

    function automatic word_t encode(input kind_e k, input logic [4:0] d,
                                     input logic [4:0] a, input logic [4:0] b, input int im);
        logic [31:0] v;
        v = 32'(im);
        case (k)
            K_ADD:   return {7'b0000000, b, a, 3'b000, d, 7'b0110011};
            K_SUB:   return {7'b0100000, b, a, 3'b000, d, 7'b0110011};
            K_AND:   return {7'b0000000, b, a, 3'b111, d, 7'b0110011};
            K_OR:    return {7'b0000000, b, a, 3'b110, d, 7'b0110011};
            K_XOR:   return {7'b0000000, b, a, 3'b100, d, 7'b0110011};
            K_SLT:   return {7'b0000000, b, a, 3'b010, d, 7'b0110011};
            K_ADDI:  return {v[11:0], a, 3'b000, d, 7'b0010011};
            K_LUI:   return {v[19:0], d, 7'b0110111};
            K_LW:    return {v[11:0], a, 3'b010, d, 7'b0000011};
            K_SW:    return {v[11:5], b, a, 3'b010, v[4:0], 7'b0100011};
            K_BEQ:   return {v[12], v[10:5], b, a, 3'b000, v[4:1], v[11], 7'b1100011};
            default: return {v[20], v[10:1], v[11], v[19:12], d, 7'b1101111};
        endcase
    endfunction

    task automatic gen_program();
        int sel;
        int k;
        for (int i = 0; i < BODY_LEN; i++) begin
            sel     = int'($urandom % 12);
            kind[i] = kind_e'(sel);
            rd[i]   = 5'($urandom % 7 + 1);
            rs1[i]  = 5'($urandom % 7 + 1);
            rs2[i]  = 5'($urandom % 7 + 1);
            imm[i]  = 0;
            // No room for a forward jump this close to the epilogue
            if ((kind[i] == K_BEQ || kind[i] == K_JAL) && i > BODY_LEN - 2) begin
                kind[i] = K_ADDI;
            end
            case (kind[i])
                K_ADDI: imm[i] = int'($urandom % 4096) - 2048;
                K_LUI:  imm[i] = int'($urandom % 1048576);
                K_LW, K_SW: begin
                    rs1[i] = 5'd0;
                    imm[i] = 4 * int'($urandom % 48);
                end
                K_BEQ, K_JAL: begin
                    k = 2 + int'($urandom % 3);
                    if (i + k > BODY_LEN) begin
                        k = BODY_LEN - i;
                    end
                    imm[i] = 4 * k;
                end
                default: imm[i] = 0;
            endcase
        end
        // Epilogue dumps x1..x7, then spins
        for (int j = 0; j < 7; j++) begin
            kind[BODY_LEN + j] = K_SW;
            rd[BODY_LEN + j]   = 5'd0;
            rs1[BODY_LEN + j]  = 5'd0;
            rs2[BODY_LEN + j]  = 5'(j + 1);
            imm[BODY_LEN + j]  = 4 * (56 + j);
        end
        kind[PROG_LEN-1] = K_JAL;
        rd[PROG_LEN-1]   = 5'd0;
        rs1[PROG_LEN-1]  = 5'd0;
        rs2[PROG_LEN-1]  = 5'd0;
        imm[PROG_LEN-1]  = 0;
    endtask

    // ISA level interpreter that records the ordered store stream
    task automatic run_model();
        word_t r [32];
        word_t m [64];
        word_t a;
        word_t b;
        word_t res;
        logic  wr;
        int    i;
        int    nxt;
        for (int n = 0; n < 32; n++) begin
            r[n] = '0;
        end
        for (int n = 0; n < 64; n++) begin
            m[n] = '0;
        end
        exp_addr.delete();
        exp_data.delete();
        i = 0;
        while (!(kind[i] == K_JAL && imm[i] == 0)) begin
            a   = r[rs1[i]];
            b   = r[rs2[i]];
            res = '0;
            wr  = 1'b1;
            nxt = i + 1;
            case (kind[i])
                K_ADD:  res = a + b;
                K_SUB:  res = a - b;
                K_AND:  res = a & b;
                K_OR:   res = a | b;
                K_XOR:  res = a ^ b;
                K_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                K_ADDI: res = a + 32'(imm[i]);
                K_LUI:  res = 32'(imm[i]) << 12;
                K_LW:   res = m[imm[i] / 4];
                K_SW: begin
                    wr = 1'b0;
                    m[imm[i] / 4] = b;
                    exp_addr.push_back(daddr_t'(imm[i] / 4));
                    exp_data.push_back(b);
                end
                K_BEQ: begin
                    wr = 1'b0;
                    if (a == b) begin
                        nxt = i + imm[i] / 4;
                    end
                end
                default: begin
                    res = 32'(4 * i + 4);
                    nxt = i + imm[i] / 4;
                end
            endcase
            if (wr && rd[i] != 5'd0) begin
                r[rd[i]] = res;
            end
            i = nxt;
        end
    endtask

    task automatic load_program();
        gen_program();
        run_model();
        for (int n = 0; n < 64; n++) begin
            imem[n] = (n < PROG_LEN) ? encode(kind[n], rd[n], rs1[n], rs2[n], imm[n]) : '0;
            dmem[n] = '0;
        end
        seen    = 0;
        pend_en = 1'b0;
    endtask

    // Store strobe is stable at the falling edge
    always @(negedge clk) begin
        if (arst_n && dmem_w_en) begin
            if (seen >= exp_addr.size()) begin
                abort_run($sformatf("program %0d stored to word %0d after its final store",
                                    prog, dmem_addr));
            end else begin
                check_addr($sformatf("prog %0d store %0d addr", prog, seen),
                           exp_addr[seen], dmem_addr);
                check_data($sformatf("prog %0d store %0d data", prog, seen),
                           exp_data[seen], dmem_wdata);
                pend_en   = 1'b1;
                pend_addr = dmem_addr;
                pend_data = dmem_wdata;
                seen++;
            end
        end
    end

    // Data memory write on the rising edge
    always @(posedge clk) begin
        if (pend_en) begin
            dmem[pend_addr] = pend_data;
            pend_en = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            abort_run($sformatf("timeout after %0d cycles in program %0d", CYCLE_LIMIT, prog));
        end
    end

    initial begin
        void'($urandom(92200));
        restart    = 1'b0;
        cycles     = 0;
        fail_count = 0;
        prog       = 0;
        for (int p = 0; p < NUM_PROGS; p++) begin
            if (p > 0) begin
                @(posedge clk);
                #10 restart = 1'b1;
                @(posedge clk);
                #10 restart = 1'b0;
            end
            prog = p;
            load_program();
            wait (arst_n);
            while (seen < exp_addr.size()) begin
                @(posedge clk);
            end
            // Quiet window behind the final store
            repeat (8) @(posedge clk);
        end
        if (fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- cpu.f
src/cpu_pkg.sv
src/fetch.sv
src/decode.sv
src/regfile.sv
src/execute.sv
src/memory_access.sv
src/hazard_detect.sv
src/cpu.sv
verification/cpu_clkgen.sv
verification/cpu_assert.sv
verification/cpu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module cpu_tb -f cpu.f -o cpu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/cpu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q '^\*\* PASS \*\*$'; then
    exit 0
fi
exit 1
